// File: include/zx_mem_cfg.svh
// Memory paging configuration
`ifndef ZX_MEM_CFG_SVH
`define ZX_MEM_CFG_SVH

// ==============================
// Physical memory geometry
// ==============================

// Physical 16K bank number
`define ZX_BANK_W 7

// Byte offset inside one bank
`define ZX_OFFSET_W 14

// Bank number followed by offset
`define ZX_RAM_ADDR_W 21

// ==============================
// CPU address space
// ==============================

// One slot per 16K quarter
`define ZX_SLOT_COUNT 4

// Upper bank bits of the ROM area
`define ZX_ROM_PREFIX 3'b101

`endif

// File: hw/zx_mem_pkg.sv
// Memory paging types
`include "zx_mem_cfg.svh"

package zx_mem_pkg;

	// ==============================
	// Machine models
	// ==============================

	// Values follow the model selector encoding
	// Unlisted codes fall back to standard 128K
	typedef enum logic [2:0] {
		std128  = 3'd0,
		pent512 = 3'd1,
		zx48    = 3'd3,
		plus3   = 3'd4
	} model_t;

	// ==============================
	// Slot table
	// ==============================

	// One entry per CPU quarter
	typedef struct packed {
		logic [`ZX_BANK_W-1:0] bank;
		logic                  writable;
	} slot_entry_t;

endpackage

// File: hw/paging_if.sv
// Paging state bus
interface paging_if;

	// Last value written to port 7FFD
	logic [7:0] page_reg;

	// Last value written to port 1FFD
	logic [7:0] page_plus3;

	// Pentagon extra RAM bank bits
	logic [1:0] page_ext;

	// Model latched during reset
	zx_mem_pkg::model_t model;

	// Register block owns the state
	modport regs (
		output page_reg,
		output page_plus3,
		output page_ext,
		output model
	);

	// Slot mappers only look at it
	modport slot (
		input page_reg,
		input page_plus3,
		input page_ext,
		input model
	);

endinterface

// File: hw/paging_regs.sv
// Paging port registers
module paging_regs (
	input  logic          clk_sys,
	input  logic          reset,
	input  logic [2:0]    model_sel,
	input  logic [15:0]   addr,
	input  logic [7:0]    data,
	input  logic          io_wr,
	paging_if.regs        pg,
	output logic          screen_page,
	output logic          paging_locked
);

	logic io_wr_d;
	logic io_wr_rise;
	logic is_plus3;
	logic is_pent;
	logic is_zx48;
	logic wr_7ffd;
	logic wr_1ffd;

	// ==============================
	// Model decode
	// ==============================

	assign is_plus3 = (pg.model == zx_mem_pkg::plus3);
	assign is_pent  = (pg.model == zx_mem_pkg::pent512);
	assign is_zx48  = (pg.model == zx_mem_pkg::zx48);

	// 48K never pages, others lock via 7FFD bit 5
	assign paging_locked = is_zx48 | pg.page_reg[5];
	assign screen_page   = pg.page_reg[3];

	// ==============================
	// Port decode
	// ==============================

	// Write strobe is the first cycle of io_wr
	assign io_wr_rise = io_wr & ~io_wr_d;

	// Partial decode, +3 also needs A14 high
	assign wr_7ffd = io_wr_rise & ~addr[15] & ~addr[1]
		& (addr[14] | ~is_plus3) & ~paging_locked;

	// 1FFD exists only on +2A/+3
	assign wr_1ffd = io_wr_rise & is_plus3 & (addr[15:12] == 4'b0001)
		& ~addr[1] & ~paging_locked;

	// ==============================
	// Registers
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			// Model follows the selector only while in reset
			pg.model      <= zx_mem_pkg::model_t'(model_sel);
			pg.page_reg   <= '0;
			pg.page_plus3 <= '0;
			pg.page_ext   <= '0;
			io_wr_d       <= 1'b0;
		end else begin
			io_wr_d <= io_wr;
			if (wr_7ffd) begin
				pg.page_reg <= data;
				// Pentagon takes two more bank bits from D7:D6
				if (is_pent) begin
					pg.page_ext <= data[7:6];
				end
			end else if (wr_1ffd) begin
				pg.page_plus3 <= data;
			end
		end
	end

	// Special modes and ROM bits of 1FFD are +3 only
	a_plus3_port_only: assert property (
		@(posedge clk_sys) disable iff (reset)
		!is_plus3 |-> (pg.page_plus3 == 8'h00)
	) else $error("1FFD state set on a model without that port");

endmodule

// File: hw/slot_mapper.sv
// Slot bank mapper
`include "zx_mem_cfg.svh"

module slot_mapper #(
	parameter int SLOT = 0
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	paging_if.slot                 pg,
	output zx_mem_pkg::slot_entry_t entry
);

	logic                  is_plus3;
	logic                  is_zx48;
	logic                  special;
	logic [3:0]            rom_num;
	logic [2:0]            spec_page;
	logic [`ZX_BANK_W-1:0] norm_bank;
	logic [`ZX_BANK_W-1:0] spec_bank;
	zx_mem_pkg::slot_entry_t next_entry;

	assign is_plus3 = (pg.model == zx_mem_pkg::plus3);
	assign is_zx48  = (pg.model == zx_mem_pkg::zx48);

	// All-RAM mode, only reachable through 1FFD
	assign special = pg.page_plus3[0];

	// ==============================
	// Normal paging
	// ==============================

	// +3 has four ROMs, older models two
	always_comb begin
		if (is_plus3) begin
			rom_num = {2'b10, pg.page_plus3[2], pg.page_reg[4]};
		end else begin
			rom_num = {3'b011, is_zx48 | pg.page_reg[4]};
		end
	end

	always_comb begin
		case (SLOT)
			0:       norm_bank = {`ZX_ROM_PREFIX, rom_num};
			1:       norm_bank = 7'd5;
			2:       norm_bank = 7'd2;
			default: norm_bank = {2'b00, pg.page_ext, pg.page_reg[2:0]};
		endcase
	end

	// ==============================
	// Special paging
	// ==============================

	// Tables 0123, 4567, 4563, 4763
	always_comb begin
		case (pg.page_plus3[2:1])
			2'b00:   spec_page = 3'(SLOT);
			2'b01:   spec_page = 3'(SLOT + 4);
			2'b10:   spec_page = (SLOT == 3) ? 3'd3 : 3'(SLOT + 4);
			default: spec_page = (SLOT == 1) ? 3'd7 : (SLOT == 3) ? 3'd3 : 3'(SLOT + 4);
		endcase
	end

	assign spec_bank = {4'b0000, spec_page};

	always_comb begin
		next_entry.bank     = special ? spec_bank : norm_bank;
		next_entry.writable = special | (SLOT != 0);
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			entry <= '0;
		end else begin
			entry <= next_entry;
		end
	end

	// ROM area must stay read-only whatever the ports hold
	a_rom_read_only: assert property (
		@(posedge clk_sys) disable iff (reset)
		(entry.bank[`ZX_BANK_W-1 -: 3] == `ZX_ROM_PREFIX) |-> !entry.writable
	) else $error("Slot %0d maps a writable ROM bank", SLOT);

endmodule

// File: hw/bank_select.sv
// Physical address selector
`include "zx_mem_cfg.svh"

module bank_select (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic [15:0]                 addr,
	input  logic                        mem_wr,
	input  zx_mem_pkg::slot_entry_t     slots [`ZX_SLOT_COUNT],
	output logic [`ZX_RAM_ADDR_W-1:0]   ram_addr,
	output logic                        ram_we
);

	zx_mem_pkg::slot_entry_t cur;

	// Top two address bits pick the quarter
	assign cur = slots[addr[15:14]];

	// CPU write gated by the slot permission
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ram_we <= 1'b0;
		end else begin
			ram_we <= mem_wr & cur.writable;
		end
	end

	// Bank on top, CPU offset below
	always_ff @(posedge clk_sys) begin
		ram_addr <= {cur.bank, addr[`ZX_OFFSET_W-1:0]};
	end

	// No memory write without a CPU write one cycle earlier
	a_we_follows_wr: assert property (
		@(posedge clk_sys) disable iff (reset)
		ram_we |-> $past(mem_wr)
	) else $error("ram_we raised without mem_wr");

endmodule

// File: hw/zx_memory_map.sv
// ZX Spectrum memory paging unit
`include "zx_mem_cfg.svh"

module zx_memory_map (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic [2:0]                  model_sel,
	input  logic [15:0]                 addr,
	input  logic [7:0]                  data,
	input  logic                        io_wr,
	input  logic                        mem_wr,
	output logic [`ZX_RAM_ADDR_W-1:0]   ram_addr,
	output logic                        ram_we,
	output logic                        screen_page,
	output logic                        paging_locked
);

	paging_if pg_bus ();

	zx_mem_pkg::slot_entry_t slot_table [`ZX_SLOT_COUNT];

	// ==============================
	// Port registers
	// ==============================

	paging_regs u_regs (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.model_sel     (model_sel),
		.addr          (addr),
		.data          (data),
		.io_wr         (io_wr),
		.pg            (pg_bus.regs),
		.screen_page   (screen_page),
		.paging_locked (paging_locked)
	);

	// One mapper per 16K quarter
	for (genvar i = 0; i < `ZX_SLOT_COUNT; i++) begin : g_slot
		slot_mapper #(
			.SLOT (i)
		) u_slot (
			.clk_sys (clk_sys),
			.reset   (reset),
			.pg      (pg_bus.slot),
			.entry   (slot_table[i])
		);
	end

	// ==============================
	// Address output
	// ==============================

	bank_select u_select (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.addr     (addr),
		.mem_wr   (mem_wr),
		.slots    (slot_table),
		.ram_addr (ram_addr),
		.ram_we   (ram_we)
	);

endmodule

// File: verification/map_checker.sv
// Paging unit output checker
`include "zx_mem_cfg.svh"

module map_checker (
	input  logic                      clk_sys,
	input  logic                      check,
	input  int                        test_num,
	input  logic [`ZX_RAM_ADDR_W-1:0] exp_ram_addr,
	input  logic                      exp_we,
	input  logic                      exp_screen,
	input  logic                      exp_locked,
	input  logic [`ZX_RAM_ADDR_W-1:0] ram_addr,
	input  logic                      ram_we,
	input  logic                      screen_page,
	input  logic                      paging_locked,
	output int                        pass_count,
	output int                        fail_count
);
	timeunit 1ns;
	timeprecision 1ps;

	task automatic compare_outputs();
		int errs;
		errs = 0;
		if (ram_addr !== exp_ram_addr) begin
			$display("FAIL %0t: test %0d ram_addr is %h, expected %h",
				$time, test_num, ram_addr, exp_ram_addr);
			errs++;
		end
		if (ram_we !== exp_we) begin
			$display("FAIL %0t: test %0d ram_we is %b, expected %b",
				$time, test_num, ram_we, exp_we);
			errs++;
		end
		if (screen_page !== exp_screen) begin
			$display("FAIL %0t: test %0d screen_page is %b, expected %b",
				$time, test_num, screen_page, exp_screen);
			errs++;
		end
		if (paging_locked !== exp_locked) begin
			$display("FAIL %0t: test %0d paging_locked is %b, expected %b",
				$time, test_num, paging_locked, exp_locked);
			errs++;
		end
		if (errs == 0) begin
			pass_count++;
			$display("Test %0d passed", test_num);
		end else begin
			fail_count++;
			$display("Test %0d failed with %0d mismatches", test_num, errs);
		end
	endtask

	// Falling edge sits midway between output updates
	initial begin
		pass_count = 0;
		fail_count = 0;
		forever begin
			@(negedge clk_sys);
			if (check) begin
				compare_outputs();
			end
		end
	end

endmodule

// File: verification/tb_zx_memory_map.sv
// Memory paging unit testbench
`include "zx_mem_cfg.svh"

module tb_zx_memory_map;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD      = 100;
	localparam int NUM_ROWS        = 24;
	localparam int WATCHDOG_CYCLES = NUM_ROWS * 8 + 20;

	localparam logic [2:0] M_128  = zx_mem_pkg::std128;
	localparam logic [2:0] M_PENT = zx_mem_pkg::pent512;
	localparam logic [2:0] M_48   = zx_mem_pkg::zx48;
	localparam logic [2:0] M_P3   = zx_mem_pkg::plus3;

	// Port 0000 marks a row without a port write
	typedef struct packed {
		logic [2:0]            model;
		logic [15:0]           port;
		logic [7:0]            wdata;
		logic [1:0]            slot;
		logic                  mem_wr;
		logic [`ZX_BANK_W-1:0] bank;
		logic                  we;
		logic                  screen;
		logic                  locked;
	} row_t;

	// ==============================
	// Stimulus table
	// ==============================

	// Model, port, data, slot, mem_wr, then bank, we, screen, locked
	row_t rows [NUM_ROWS] = '{
		'{M_128,  16'h0000, 8'h00, 2'd0, 1'b1, 7'h56, 1'b0, 1'b0, 1'b0},
		'{M_128,  16'h0000, 8'h00, 2'd1, 1'b1, 7'h05, 1'b1, 1'b0, 1'b0},
		'{M_128,  16'h0000, 8'h00, 2'd2, 1'b1, 7'h02, 1'b1, 1'b0, 1'b0},
		'{M_128,  16'h0000, 8'h00, 2'd3, 1'b1, 7'h00, 1'b1, 1'b0, 1'b0},
		'{M_128,  16'h7FFD, 8'h1B, 2'd3, 1'b1, 7'h03, 1'b1, 1'b1, 1'b0},
		'{M_128,  16'h0000, 8'h00, 2'd0, 1'b1, 7'h57, 1'b0, 1'b1, 1'b0},
		// Bit 5 locks, the next write must be dropped
		'{M_128,  16'h7FFD, 8'h24, 2'd3, 1'b0, 7'h04, 1'b0, 1'b0, 1'b1},
		'{M_128,  16'h7FFD, 8'h07, 2'd3, 1'b1, 7'h04, 1'b1, 1'b0, 1'b1},
		'{M_128,  16'h0000, 8'h00, 2'd0, 1'b0, 7'h56, 1'b0, 1'b0, 1'b1},
		'{M_PENT, 16'h7FFD, 8'hC6, 2'd3, 1'b1, 7'h1E, 1'b1, 1'b0, 1'b0},
		'{M_48,   16'h0000, 8'h00, 2'd0, 1'b1, 7'h57, 1'b0, 1'b0, 1'b1},
		'{M_48,   16'h7FFD, 8'h1F, 2'd3, 1'b1, 7'h00, 1'b1, 1'b0, 1'b1},
		'{M_P3,   16'h0000, 8'h00, 2'd0, 1'b1, 7'h58, 1'b0, 1'b0, 1'b0},
		// Special tables 0123, 4567, 4563, 4763
		'{M_P3,   16'h1FFD, 8'h01, 2'd0, 1'b1, 7'h00, 1'b1, 1'b0, 1'b0},
		'{M_P3,   16'h0000, 8'h00, 2'd3, 1'b1, 7'h03, 1'b1, 1'b0, 1'b0},
		'{M_P3,   16'h1FFD, 8'h03, 2'd0, 1'b1, 7'h04, 1'b1, 1'b0, 1'b0},
		'{M_P3,   16'h0000, 8'h00, 2'd3, 1'b1, 7'h07, 1'b1, 1'b0, 1'b0},
		'{M_P3,   16'h1FFD, 8'h05, 2'd3, 1'b1, 7'h03, 1'b1, 1'b0, 1'b0},
		'{M_P3,   16'h1FFD, 8'h07, 2'd1, 1'b1, 7'h07, 1'b1, 1'b0, 1'b0},
		'{M_P3,   16'h0000, 8'h00, 2'd2, 1'b1, 7'h06, 1'b1, 1'b0, 1'b0},
		'{M_P3,   16'h1FFD, 8'h04, 2'd0, 1'b1, 7'h5A, 1'b0, 1'b0, 1'b0},
		'{M_P3,   16'h7FFD, 8'h10, 2'd0, 1'b1, 7'h5B, 1'b0, 1'b0, 1'b0},
		// A14 low, so 7FFD keeps its value
		'{M_P3,   16'h3FFD, 8'h07, 2'd3, 1'b1, 7'h00, 1'b1, 1'b0, 1'b0},
		'{M_P3,   16'h0000, 8'h00, 2'd0, 1'b0, 7'h5B, 1'b0, 1'b0, 1'b0}
	};

	logic        clk_sys;
	logic        reset;
	logic [2:0]  model_sel;
	logic [15:0] addr;
	logic [7:0]  data;
	logic        io_wr;
	logic        mem_wr;
	logic [`ZX_RAM_ADDR_W-1:0] ram_addr;
	logic        ram_we;
	logic        screen_page;
	logic        paging_locked;

	logic        check;
	int          test_num;
	logic [`ZX_RAM_ADDR_W-1:0] exp_ram_addr;
	logic        exp_we;
	logic        exp_screen;
	logic        exp_locked;
	int          pass_count;
	int          fail_count;
	logic [15:0] lfsr_state;

	zx_memory_map dut (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.model_sel     (model_sel),
		.addr          (addr),
		.data          (data),
		.io_wr         (io_wr),
		.mem_wr        (mem_wr),
		.ram_addr      (ram_addr),
		.ram_we        (ram_we),
		.screen_page   (screen_page),
		.paging_locked (paging_locked)
	);

	map_checker u_check (
		.clk_sys       (clk_sys),
		.check         (check),
		.test_num      (test_num),
		.exp_ram_addr  (exp_ram_addr),
		.exp_we        (exp_we),
		.exp_screen    (exp_screen),
		.exp_locked    (exp_locked),
		.ram_addr      (ram_addr),
		.ram_we        (ram_we),
		.screen_page   (screen_page),
		.paging_locked (paging_locked),
		.pass_count    (pass_count),
		.fail_count    (fail_count)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		$display("Done: errors found");
		$finish;
	end

	// Galois form, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 16'hB400;
		end
		return state >> 1;
	endfunction

	task automatic take_offset(output logic [`ZX_OFFSET_W-1:0] offset);
		for (int b = 0; b < `ZX_OFFSET_W; b++) begin
			offset[b] = lfsr_state[0];
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	task automatic wait_drive_point();
		@(posedge clk_sys);
		#10;
	endtask

	task automatic apply_reset(input logic [2:0] model);
		reset = 1'b1;
		model_sel = model;
		repeat (4) @(posedge clk_sys);
		#10;
		reset = 1'b0;
	endtask

	// ==============================
	// Table sequencing
	// ==============================

	initial begin
		logic [`ZX_OFFSET_W-1:0] offset;
		logic [2:0]              cur_model;
		reset = 1'b1;
		model_sel = M_128;
		addr = 16'h0000;
		data = 8'h00;
		io_wr = 1'b0;
		mem_wr = 1'b0;
		check = 1'b0;
		test_num = 0;
		exp_ram_addr = '0;
		exp_we = 1'b0;
		exp_screen = 1'b0;
		exp_locked = 1'b0;
		lfsr_state = 16'd38688;
		cur_model = M_128;
		wait_drive_point();
		for (int i = 0; i < NUM_ROWS; i++) begin
			// Model is only latched in reset
			if (i == 0 || rows[i].model != cur_model) begin
				apply_reset(rows[i].model);
				cur_model = rows[i].model;
			end
			if (rows[i].port != 16'h0000) begin
				addr = rows[i].port;
				data = rows[i].wdata;
				io_wr = 1'b1;
			end
			wait_drive_point();
			io_wr = 1'b0;
			repeat (2) wait_drive_point();
			take_offset(offset);
			addr = {rows[i].slot, offset};
			mem_wr = rows[i].mem_wr;
			wait_drive_point();
			test_num = i;
			exp_ram_addr = {rows[i].bank, offset};
			exp_we = rows[i].we;
			exp_screen = rows[i].screen;
			exp_locked = rows[i].locked;
			check = 1'b1;
			wait_drive_point();
			check = 1'b0;
			mem_wr = 1'b0;
		end
		wait_drive_point();
		$display("Summary: %0d tests, %0d passed, %0d failed", NUM_ROWS, pass_count, fail_count);
		if (pass_count == NUM_ROWS && fail_count == 0) begin
			$display("Done: no errors");
		end else begin
			if (pass_count + fail_count != NUM_ROWS) begin
				$display("Some tests never reached the checker");
			end
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// File: list.f
+incdir+include
hw/zx_mem_pkg.sv
hw/paging_if.sv
hw/paging_regs.sv
hw/slot_mapper.sv
hw/bank_select.sv
hw/zx_memory_map.sv
verification/map_checker.sv
verification/tb_zx_memory_map.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the memory paging testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_zx_memory_map
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --assert --timescale 1ns/1ps \
	--top-module "$TOP" -Mdir "$BUILD_DIR" -f list.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q -x -F "Done: no errors" "$LOG"; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed"
	exit 1
fi
